/* hdl/lc3b_types.sv */
package lc3b_types;

// --------------------
// Widths
// --------------------

localparam int WORD_W = 16;                        // Byte address width.
localparam int LINE_W = 128;                       // Bits in one cache line.
localparam int OFFSET_W = 4;                       // Byte offset within a line.
localparam int LINE_ADDR_W = WORD_W - OFFSET_W;    // Line number width.

// --------------------
// Vector types
// --------------------

typedef logic [WORD_W-1:0] lc3b_word;              // Byte address as seen by the cache.
typedef logic [LINE_W-1:0] lc3b_cacheline;         // Full line of data.
typedef logic [LINE_ADDR_W-1:0] lc3b_line_addr;    // Byte address without its offset.

endpackage : lc3b_types

/* hdl/evict_ctrl_pkg.sv */
package evict_ctrl_pkg;

import lc3b_types::*;

// --------------------
// Request and command
// --------------------

// One line moving between the request port, the buffer and the memory port.
typedef struct packed {
	logic is_write;                      // Write request or drained entry.
	lc3b_line_addr addr;                 // Line address.
	lc3b_cacheline data;                 // Line payload.
} line_req_t;

// Command toward physical memory.
typedef struct packed {
	logic read;                          // Line read.
	logic write;                         // Line write.
	lc3b_word address;                   // Byte address, offset zero.
	lc3b_cacheline wdata;                // Write payload.
} mem_cmd_t;

// --------------------
// State machines
// --------------------

typedef enum logic [1:0] {
	REQ_IDLE,                            // Waiting for a cache request.
	REQ_LOOKUP,                          // Request presented to the buffer.
	REQ_WAIT_FILL,                       // Read miss waiting for memory.
	REQ_RESPOND                          // Response pulse to the cache.
} req_state_e;

typedef enum logic [1:0] {
	MEM_IDLE,                            // Memory port free.
	MEM_FILL,                            // Read miss in flight.
	MEM_DRAIN                            // Buffered line being written back.
} mem_state_e;

endpackage : evict_ctrl_pkg

/* hdl/evict_req_port.sv */
module evict_req_port
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  logic cache_read,
	input  logic cache_write,
	input  lc3b_word cache_address,
	input  lc3b_cacheline cache_wdata,
	output logic cache_resp,
	output lc3b_cacheline cache_rdata,
	output line_req_t lookup,
	output logic lookup_valid,
	input  logic hit,
	input  lc3b_cacheline hit_data,
	input  logic push_ready,
	output logic push,
	output line_req_t fill_req,
	output logic fill_valid,
	input  logic fill_done,
	input  lc3b_cacheline fill_data
);

req_state_e state;
req_state_e state_next;
line_req_t req;                                    // Captured cache request.
lc3b_cacheline rdata;                              // Read data held for the response.

always_ff @(posedge buf_mem_resp or negedge rst_n)
begin
	if (!rst_n)
		state <= REQ_IDLE;
	else
		state <= state_next;
end

always_comb
begin
	state_next = state;
	case (state)
		REQ_IDLE:
			if (cache_read || cache_write)
				state_next = REQ_LOOKUP;
		REQ_LOOKUP:
			if (req.is_write)
			begin
				if (hit || push_ready)
					state_next = REQ_RESPOND;      // Otherwise stall on a full buffer.
			end
			else if (hit)
				state_next = REQ_RESPOND;
			else
				state_next = REQ_WAIT_FILL;
		REQ_WAIT_FILL:
			if (fill_done)
				state_next = REQ_RESPOND;
		REQ_RESPOND:
			state_next = REQ_IDLE;
		default:
			state_next = REQ_IDLE;
	endcase
end

// --------------------
// Request and data capture
// --------------------

always_ff @(posedge buf_mem_resp)
begin
	if (state == REQ_IDLE && (cache_read || cache_write))
	begin
		req.is_write <= cache_write;
		req.addr <= cache_address[15:4];           // Drop the byte offset.
		req.data <= cache_wdata;
	end
	if (state == REQ_LOOKUP && !req.is_write && hit)
		rdata <= hit_data;
	if (state == REQ_WAIT_FILL && fill_done)
		rdata <= fill_data;
end

assign lookup = req;
assign lookup_valid = (state == REQ_LOOKUP);
assign push = (state == REQ_LOOKUP) && req.is_write && (hit || push_ready);
assign fill_req = req;
assign fill_valid = (state == REQ_WAIT_FILL);      // Held until fill_done.
assign cache_resp = (state == REQ_RESPOND);
assign cache_rdata = rdata;

endmodule : evict_req_port

/* hdl/eviction_buffer.sv */
module eviction_buffer
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  line_req_t lookup,
	input  logic lookup_valid,
	input  logic push,
	output logic hit,
	output lc3b_cacheline hit_data,
	output logic push_ready,
	output line_req_t drain_head,
	output logic drain_valid,
	input  logic drain_pop
);

localparam int PTR_W = $clog2(DEPTH);

typedef logic [PTR_W-1:0] ptr_t;
typedef logic [PTR_W:0] count_t;

logic [DEPTH-1:0] valid;
lc3b_line_addr entry_addr [DEPTH];
lc3b_cacheline entry_data [DEPTH];
ptr_t head;                                        // Oldest entry, next to drain.
ptr_t tail;                                        // Next free slot.
count_t count;
logic [DEPTH-1:0] match;
ptr_t hit_idx;
logic alloc;
logic overwrite;

// --------------------
// Address match
// --------------------

// The head entry is excluded while it pops, so a write in that cycle
// lands in a fresh slot instead of an entry about to disappear.
always_comb
begin
	match = '0;
	hit_idx = '0;
	for (int i = 0; i < DEPTH; i++)
	begin
		match[i] = valid[i] && (entry_addr[i] == lookup.addr) &&
			!(drain_pop && (ptr_t'(i) == head));
		if (match[i])
			hit_idx = ptr_t'(i);                   // At most one entry per line.
	end
end

assign hit = lookup_valid && (|match);
assign hit_data = entry_data[hit_idx];
assign push_ready = (count < count_t'(DEPTH));

assign alloc = push && lookup.is_write && !hit;
assign overwrite = push && lookup.is_write && hit;

// --------------------
// FIFO control
// --------------------

always_ff @(posedge buf_mem_resp or negedge rst_n)
begin
	if (!rst_n)
	begin
		valid <= '0;
		head <= '0;
		tail <= '0;
		count <= '0;
	end
	else
	begin
		if (alloc)
		begin
			valid[tail] <= 1'b1;
			tail <= tail + 1'b1;
		end
		if (drain_pop)
		begin
			valid[head] <= 1'b0;
			head <= head + 1'b1;
		end
		case ({alloc, drain_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge buf_mem_resp)
begin
	if (alloc)
	begin
		entry_addr[tail] <= lookup.addr;
		entry_data[tail] <= lookup.data;
	end
	else if (overwrite)
		entry_data[hit_idx] <= lookup.data;        // In-place update of a buffered line.
end

assign drain_valid = (count != '0);
assign drain_head.is_write = 1'b1;
assign drain_head.addr = entry_addr[head];
assign drain_head.data = entry_data[head];

endmodule : eviction_buffer

/* hdl/mem_port_ctrl.sv */
module mem_port_ctrl
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  line_req_t fill_req,
	input  logic fill_valid,
	output logic fill_done,
	output lc3b_cacheline fill_data,
	input  line_req_t drain_head,
	input  logic drain_valid,
	output logic drain_pop,
	output mem_cmd_t mem_cmd,
	input  logic mem_resp,
	input  lc3b_cacheline mem_rdata
);

mem_state_e state;
logic cmd_read;
logic cmd_write;
lc3b_word cmd_address;
lc3b_cacheline cmd_wdata;

// Line number back to a byte address at offset zero.
function automatic lc3b_word to_word_addr(input lc3b_line_addr line);
	return {line, {OFFSET_W{1'b0}}};
endfunction

// --------------------
// Arbitration
// --------------------

always_ff @(posedge buf_mem_resp or negedge rst_n)
begin
	if (!rst_n)
	begin
		state <= MEM_IDLE;
		cmd_read <= 1'b0;
		cmd_write <= 1'b0;
	end
	else
	begin
		case (state)
			MEM_IDLE:
				if (fill_valid)
				begin
					state <= MEM_FILL;             // Read misses go first.
					cmd_read <= 1'b1;
				end
				else if (drain_valid)
				begin
					state <= MEM_DRAIN;
					cmd_write <= 1'b1;
				end
			MEM_FILL, MEM_DRAIN:
				if (mem_resp)
				begin
					state <= MEM_IDLE;
					cmd_read <= 1'b0;
					cmd_write <= 1'b0;
				end
			default:
				state <= MEM_IDLE;
		endcase
	end
end

always_ff @(posedge buf_mem_resp)
begin
	if (state == MEM_IDLE)
	begin
		if (fill_valid)
			cmd_address <= to_word_addr(fill_req.addr);
		else if (drain_valid)
		begin
			cmd_address <= to_word_addr(drain_head.addr);
			cmd_wdata <= drain_head.data;          // Snapshot of the head entry.
		end
	end
end

assign mem_cmd.read = cmd_read;
assign mem_cmd.write = cmd_write;
assign mem_cmd.address = cmd_address;
assign mem_cmd.wdata = cmd_wdata;

assign fill_done = (state == MEM_FILL) && mem_resp;
assign fill_data = mem_rdata;

// Head rewritten while its drain was in flight.  Keep it for another pass.
assign drain_pop = (state == MEM_DRAIN) && mem_resp && (drain_head.data == cmd_wdata);

endmodule : mem_port_ctrl

/* hdl/evict_top.sv */
module evict_top
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  logic cache_read,
	input  logic cache_write,
	input  lc3b_word cache_address,
	input  lc3b_cacheline cache_wdata,
	output logic cache_resp,
	output lc3b_cacheline cache_rdata,
	output mem_cmd_t mem_cmd,
	input  logic mem_resp,
	input  lc3b_cacheline mem_rdata
);

line_req_t lookup;
logic lookup_valid;
logic hit;
lc3b_cacheline hit_data;
logic push_ready;
logic push;
line_req_t fill_req;
logic fill_valid;
logic fill_done;
lc3b_cacheline fill_data;
line_req_t drain_head;
logic drain_valid;
logic drain_pop;

// --------------------
// Blocks
// --------------------

evict_req_port req_port
(
	.buf_mem_resp, .rst_n,
	.cache_read, .cache_write, .cache_address, .cache_wdata,
	.cache_resp, .cache_rdata,
	.lookup, .lookup_valid, .hit, .hit_data, .push_ready, .push,
	.fill_req, .fill_valid, .fill_done, .fill_data
);

eviction_buffer #(.DEPTH(DEPTH)) buffer
(
	.buf_mem_resp, .rst_n,
	.lookup, .lookup_valid, .push, .hit, .hit_data, .push_ready,
	.drain_head, .drain_valid, .drain_pop
);

mem_port_ctrl mem_port
(
	.buf_mem_resp, .rst_n,
	.fill_req, .fill_valid, .fill_done, .fill_data,
	.drain_head, .drain_valid, .drain_pop,
	.mem_cmd, .mem_resp, .mem_rdata
);

endmodule : evict_top

/* bench/line_memory_model.sv */
module line_memory_model
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
#(
	parameter int MEM_LATENCY = 3
)
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  mem_cmd_t mem_cmd,
	output logic mem_resp,
	output lc3b_cacheline mem_rdata
);

timeunit 1ns;
timeprecision 1ns;

lc3b_cacheline lines [2**LINE_ADDR_W];
int unsigned wait_cnt;

// Line address repeated across the whole line.
function automatic lc3b_cacheline line_fill(input lc3b_line_addr a);
	return lc3b_cacheline'({11{a}});
endfunction

initial
begin
	for (int i = 0; i < 2**LINE_ADDR_W; i++)
		lines[i] = line_fill(lc3b_line_addr'(i));
end

always @(posedge buf_mem_resp or negedge rst_n)
begin
	if (!rst_n)
	begin
		mem_resp <= 1'b0;
		mem_rdata <= '0;
		wait_cnt <= 0;
	end
	else if ((mem_cmd.read || mem_cmd.write) && !mem_resp)
	begin
		if (wait_cnt == MEM_LATENCY - 1)
		begin
			mem_resp <= 1'b1;                       // One-cycle completion pulse.
			wait_cnt <= 0;
			if (mem_cmd.write)
				lines[mem_cmd.address[15:4]] <= mem_cmd.wdata;
			else
				mem_rdata <= lines[mem_cmd.address[15:4]];
		end
		else
			wait_cnt <= wait_cnt + 1;
	end
	else
		mem_resp <= 1'b0;
end

endmodule : line_memory_model

/* bench/evict_assertions.sv */
module evict_assertions
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic buf_mem_resp,
	input  logic rst_n,
	input  logic cache_read,
	input  logic cache_write,
	input  lc3b_word cache_address,
	input  lc3b_cacheline cache_wdata,
	input  logic cache_resp,
	input  lc3b_cacheline cache_rdata,
	input  mem_cmd_t mem_cmd,
	input  logic mem_resp
);

timeunit 1ns;
timeprecision 1ns;

int unsigned errors;
lc3b_cacheline shadow [2**LINE_ADDR_W];           // Latest value of every line.
logic [2**LINE_ADDR_W-1:0] buffered;              // Lines still waiting for write-back.
logic busy;
logic seen_req;
logic blocked;
lc3b_line_addr req_line;
lc3b_line_addr cmd_line;
logic req_start;
logic mem_wr_done;
logic in_set;
int set_size;
lc3b_cacheline exp_rdata;
lc3b_cacheline exp_wdata;

function automatic lc3b_cacheline line_fill(input lc3b_line_addr a);
	return lc3b_cacheline'({11{a}});
endfunction

initial
begin
	errors = 0;
	for (int i = 0; i < 2**LINE_ADDR_W; i++)
		shadow[i] = line_fill(lc3b_line_addr'(i));
end

assign req_line = cache_address[15:4];
assign cmd_line = mem_cmd.address[15:4];
assign req_start = (cache_read || cache_write) && !busy;
assign mem_wr_done = mem_cmd.write && mem_resp;
assign in_set = buffered[req_line];
assign set_size = $countones(buffered);
assign exp_rdata = shadow[req_line];
assign exp_wdata = shadow[cmd_line];

// --------------------
// Reference state
// --------------------

always @(posedge buf_mem_resp or negedge rst_n)
begin
	if (!rst_n)
	begin
		busy <= 1'b0;
		seen_req <= 1'b0;
		blocked <= 1'b0;
		buffered <= '0;
	end
	else
	begin
		if (req_start)
		begin
			busy <= 1'b1;
			seen_req <= 1'b1;
		end
		else if (cache_resp)
			busy <= 1'b0;
		if (mem_wr_done)
			blocked <= 1'b0;                        // Space freed by a write-back.
		else if (req_start && cache_write && set_size == DEPTH && !in_set)
			blocked <= 1'b1;
		if (mem_wr_done && mem_cmd.wdata == exp_wdata)
			buffered[cmd_line] <= 1'b0;             // Only a current value retires the line.
		if (cache_resp && cache_write)
			buffered[req_line] <= 1'b1;
	end
end

always @(posedge buf_mem_resp)
begin
	if (rst_n && cache_resp && cache_write)
		shadow[req_line] <= cache_wdata;
end

// --------------------
// Checks
// --------------------

a_read_data: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	cache_resp && cache_read |-> cache_rdata == exp_rdata)
	else begin
		$error("mismatch at %0t: read data of line %0h is wrong", $time, req_line);
		errors++;
	end

a_fast_resp: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	(req_start && (in_set || (cache_write && set_size < DEPTH)) && !mem_wr_done)
	##1 !mem_wr_done |-> ##1 cache_resp)
	else begin
		$error("A buffered or unblocked request was not answered after 2 cycles");
		errors++;
	end

a_count: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	set_size <= DEPTH)
	else begin
		$error("More lines are buffered than the buffer can hold");
		errors++;
	end

a_blocked: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	cache_resp |-> !blocked)
	else begin
		$error("A write to a full buffer was answered before any write-back");
		errors++;
	end

a_exclusive: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	!(mem_cmd.read && mem_cmd.write))
	else begin
		$error("Memory read and write were raised together");
		errors++;
	end

a_stable: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	(mem_cmd.read || mem_cmd.write) && !mem_resp |=> $stable(mem_cmd))
	else begin
		$error("Memory command changed before its response");
		errors++;
	end

// A rewrite whose response is in progress may already sit in the buffer.
a_wdata: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	$rose(mem_cmd.write) |-> mem_cmd.wdata == exp_wdata ||
		(cache_write && req_line == cmd_line && cache_wdata == mem_cmd.wdata))
	else begin
		$error("mismatch at %0t: write-back data of line %0h is stale", $time, cmd_line);
		errors++;
	end

a_quiet: assert property (@(posedge buf_mem_resp) disable iff (!rst_n)
	!seen_req |-> !cache_resp && !mem_cmd.read && !mem_cmd.write)
	else begin
		$error("Outputs became active before the first request");
		errors++;
	end

endmodule : evict_assertions

bind evict_top evict_assertions #(.DEPTH(DEPTH)) chk (.*);

/* bench/evict_tb.sv */
module evict_tb
	import lc3b_types::*;
	import evict_ctrl_pkg::*;
;

timeunit 1ns;
timeprecision 1ns;

localparam int DEPTH = 4;
localparam int MEM_LATENCY = 3;
localparam int RESET_CYCLES = 10;
localparam int RANDOM_OPS = 60;
localparam int CYCLE_LIMIT = 70 * (DEPTH + 1) * (MEM_LATENCY + 4) + RESET_CYCLES;

logic buf_mem_resp;
logic rst_n;
logic cache_read;
logic cache_write;
lc3b_word cache_address;
lc3b_cacheline cache_wdata;
logic cache_resp;
lc3b_cacheline cache_rdata;
mem_cmd_t mem_cmd;
logic mem_resp;
lc3b_cacheline mem_rdata;
int unsigned lcg_state;
int cycles;

evict_top #(.DEPTH(DEPTH)) dut0
(
	.buf_mem_resp, .rst_n,
	.cache_read, .cache_write, .cache_address, .cache_wdata,
	.cache_resp, .cache_rdata,
	.mem_cmd, .mem_resp, .mem_rdata
);

line_memory_model #(.MEM_LATENCY(MEM_LATENCY)) memory
(
	.buf_mem_resp, .rst_n, .mem_cmd, .mem_resp, .mem_rdata
);

initial
	buf_mem_resp = 1'b0;

always #20 buf_mem_resp = ~buf_mem_resp;

// --------------------
// Helpers
// --------------------

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic lc3b_cacheline random_line();
	return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
endfunction

// Called 2 ns after a rising edge, returns at the same point after the response.
task automatic cache_access(input logic wr, input lc3b_line_addr line, input lc3b_cacheline d);
	cache_read = !wr;
	cache_write = wr;
	cache_address = {line, 4'h0};
	cache_wdata = d;
	do
		@(negedge buf_mem_resp);
	while (!cache_resp);
	@(posedge buf_mem_resp);
	#2;
	cache_read = 1'b0;
	cache_write = 1'b0;
endtask

// --------------------
// Watchdogs
// --------------------

always @(posedge buf_mem_resp)
begin
	cycles++;
	if (cycles > CYCLE_LIMIT)
	begin
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$fatal(1, "Simulation stopped on timeout");
	end
end

always @(negedge buf_mem_resp)
begin
	if (dut0.chk.errors != 0)
	begin
		$display("Test failed");
		$fatal(1, "Assertion failure detected");
	end
end

// --------------------
// Stimulus
// --------------------

initial
begin
	cycles = 0;
	lcg_state = 20975;
	rst_n = 1'b0;
	cache_read = 1'b0;
	cache_write = 1'b0;
	cache_address = '0;
	cache_wdata = '0;
	repeat (RESET_CYCLES) @(posedge buf_mem_resp);
	#2;
	rst_n = 1'b1;
	repeat (2) @(posedge buf_mem_resp);
	#2;

	// A drain takes five cycles and a write three.
	// About twice the depth in new lines fills the buffer.
	for (int i = 0; i < 2 * DEPTH + 2; i++)
		cache_access(1'b1, lc3b_line_addr'(i), random_line());    // Fill the buffer.
	cache_access(1'b1, lc3b_line_addr'(2 * DEPTH + 1), random_line());
	cache_access(1'b0, lc3b_line_addr'(2 * DEPTH + 1), '0);

	for (int i = 0; i < RANDOM_OPS; i++)
	begin
		logic wr;
		lc3b_line_addr line;
		int unsigned rnd;
		rnd = lcg_next();
		wr = rnd[16];
		rnd = lcg_next();
		line = lc3b_line_addr'(rnd[18:16]);
		cache_access(wr, line, random_line());
	end

	repeat (4) @(posedge buf_mem_resp);
	if (dut0.chk.errors == 0)
	begin
		$display("Test completed successfully");
		$finish;
	end
	else
	begin
		$display("Test failed");
		$fatal(1, "Checks failed during the run");
	end
end

endmodule : evict_tb

/* build.f */
hdl/lc3b_types.sv
hdl/evict_ctrl_pkg.sv
hdl/evict_req_port.sv
hdl/eviction_buffer.sv
hdl/mem_port_ctrl.sv
hdl/evict_top.sv
bench/line_memory_model.sv
bench/evict_assertions.sv
bench/evict_tb.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = evict_tb
FILELIST  = build.f
RUN_FLAGS = +verilator+error+limit+10
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
